/* biu.f */
+incdir+hw
hw/biu_bus_pkg.sv
hw/biu_core_pkg.sv
hw/biu_req_port.sv
hw/biu_bus_seq.sv
hw/biu_pin_mux.sv
hw/biu_top.sv
bench/biu_clkgen.sv
bench/biu_properties.sv
bench/biu_tb.sv

/* Makefile */
# Verilator build and run of the bus interface unit testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/Vbiu_tb

obj_dir/Vbiu_tb: biu.f hw/*.sv hw/*.svh bench/*.sv
	verilator --binary --timing --assert --top-module biu_tb -f biu.f

run: compile
	-./obj_dir/Vbiu_tb +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir sim.log

/* bench/biu_tb.sv */
/*
 * bus interface unit testbench
 * byte-wide memory model on the multiplexed bus and a table of core requests
 */

`timescale 1ns/10ps

module biu_tb;

   import biu_bus_pkg::*;
   import biu_core_pkg::*;

   localparam logic [2:0] op_rd_word = 3'd0;
   localparam logic [2:0] op_rd_byte = 3'd1;
   localparam logic [2:0] op_wr_word = 3'd2;
   localparam logic [2:0] op_wr_byte = 3'd3;
   localparam logic [2:0] op_hold    = 3'd4;  // word read issued under hold
   localparam int         n_rows     = 10;

   typedef struct packed {
      logic [2:0]  op;
      biu_addr_t   addr;
      logic [15:0] wdata;
      logic [7:0]  hold_len;  // hold cycles after the request goes out
   } row_t;

   row_t stim [0:n_rows-1] = '{
      '{op_rd_word, 20'h3a100, 16'h0000, 8'd0},
      '{op_rd_byte, 20'h0f203, 16'h0000, 8'd0},
      '{op_wr_word, 20'h00300, 16'hbeef, 8'd0},
      '{op_rd_word, 20'h00300, 16'h0000, 8'd0},  // reads back the word write
      '{op_wr_byte, 20'h00401, 16'h005a, 8'd0},
      '{op_rd_byte, 20'h00401, 16'h0000, 8'd0},
      '{op_wr_byte, 20'h12600, 16'h009c, 8'd0},
      '{op_rd_byte, 20'h12600, 16'h0000, 8'd0},  // negative byte
      '{op_hold,    20'h00510, 16'h0000, 8'd6},
      '{op_rd_word, 20'h007ff, 16'h0000, 8'd0}
   };
   string op_names [0:4] = '{"rd word", "rd byte", "wr word", "wr byte", "hold rd"};

   logic       clk, rst;
   logic       req_i, we_i, byte_i, hold_i;
   biu_addr_t  addr_i, a_o;
   biu_data_u  wdata_i, rdata_o;
   biu_byte_t  ad_i, ad_o;
   logic       ack_o, ad_oe_o, ale_o, rd_n_o, wr_n_o, den_n_o, dtr_o, hlda_o;
   logic [7:0] mem [0:4095];  // 4 KB window on the low address bits
   int         errors;

   biu_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

   biu_top u_dut (
      .clk(clk), .rst(rst), .req_i(req_i), .addr_i(addr_i), .we_i(we_i),
      .byte_i(byte_i), .wdata_i(wdata_i), .hold_i(hold_i), .ad_i(ad_i),
      .ack_o(ack_o), .rdata_o(rdata_o), .a_o(a_o), .ad_o(ad_o), .ad_oe_o(ad_oe_o),
      .ale_o(ale_o), .rd_n_o(rd_n_o), .wr_n_o(wr_n_o), .den_n_o(den_n_o),
      .dtr_o(dtr_o), .hlda_o(hlda_o)
   );

   bind biu_top biu_properties u_props (
      .clk(clk), .rst(rst), .req_i(req_i), .ack_i(ack_o), .ale_i(ale_o),
      .rd_n_i(rd_n_o), .wr_n_i(wr_n_o), .hlda_i(hlda_o), .ad_oe_i(ad_oe_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic flag_error(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      errors++;
   endtask

   // memory answers while rd_n is low
   assign ad_i = rd_n_o ? 8'h00 : mem[a_o[11:0]];

   initial begin
      logic [31:0] rnd;
      rnd = 32'd26;
      for (int i = 0; i < 4096; i++) begin
         rnd = xorshift(rnd);
         mem[i] = rnd[7:0];
      end
      forever begin
         @(negedge clk);
         if (!wr_n_o)
            mem[a_o[11:0]] = ad_o;  // write byte held through T2 and T3
      end
   end

   task automatic run_row(input int r);
      row_t        s;
      logic        is_rd, is_byte;
      int          n, lat, rd_low, wr_low, ale_cnt;
      logic [7:0]  hold_left, keep;
      logic [11:0] i0, i1;
      logic [15:0] exp_word;
      biu_addr_t   a1, a_exp;
      s = stim[r];
      is_rd = (s.op == op_rd_word) || (s.op == op_rd_byte) || (s.op == op_hold);
      is_byte = (s.op == op_rd_byte) || (s.op == op_wr_byte);
      n = is_byte ? 1 : 2;
      a1 = s.addr + 20'd1;
      i0 = s.addr[11:0];
      i1 = a1[11:0];
      keep = mem[i1];
      exp_word = is_byte ? {{8{mem[i0][7]}}, mem[i0]} : {mem[i1], mem[i0]};
      if (s.op == op_hold) begin
         @(posedge clk);
         hold_i <= 1'b1;
         do @(negedge clk); while (!hlda_o);  // granted while idle
      end
      @(posedge clk);
      req_i   <= 1'b1;
      addr_i  <= s.addr;
      we_i    <= !is_rd;
      byte_i  <= is_byte;
      wdata_i <= s.wdata;
      hold_left = s.hold_len;
      @(posedge clk);  // this edge samples req
      lat = 0;
      rd_low = 0;
      wr_low = 0;
      ale_cnt = 0;
      do begin
         @(posedge clk);
         lat++;
         if (hold_left != 8'd0) begin
            hold_left = hold_left - 8'd1;
            if (hold_left == 8'd0)
               hold_i <= 1'b0;
         end
         @(negedge clk);
         if (hlda_o)
            assert (!ale_o && rd_n_o && wr_n_o && !ad_oe_o && !ack_o)
               else flag_error($sformatf("row %0d bus activity during hold", r));
         if (ale_o) begin
            a_exp = (ale_cnt >= 1) ? a1 : s.addr;
            assert (ad_oe_o && ad_o == a_exp[7:0])
               else flag_error($sformatf("row %0d T1 ad %h oe %b expected %h", r, ad_o,
                                         ad_oe_o, a_exp[7:0]));
            ale_cnt++;
         end
         if (!rd_n_o || !wr_n_o) begin
            a_exp = (rd_low + wr_low >= 2) ? a1 : s.addr;
            assert (a_o == a_exp)
               else flag_error($sformatf("row %0d a_o %h expected %h", r, a_o, a_exp));
            assert (!den_n_o && dtr_o == !is_rd)
               else flag_error($sformatf("row %0d den_n %b dtr %b with strobe low", r,
                                         den_n_o, dtr_o));
         end
         if (!rd_n_o) rd_low++;
         if (!wr_n_o) wr_low++;
      end while (!ack_o);
      if (s.op != op_hold)
         assert (lat == 3 * n + 2)
            else flag_error($sformatf("row %0d ack after %0d cycles, expected %0d",
                                      r, lat, 3 * n + 2));
      assert (rd_low == (is_rd ? 2 * n : 0) && wr_low == (is_rd ? 0 : 2 * n) && ale_cnt == n)
         else flag_error($sformatf("row %0d strobe low rd %0d wr %0d ale %0d", r, rd_low,
                                   wr_low, ale_cnt));
      if (is_rd) begin
         assert (rdata_o.word == exp_word)
            else flag_error($sformatf("row %0d rdata %h expected %h", r, rdata_o.word,
                                      exp_word));
      end else begin
         assert (mem[i0] == s.wdata[7:0] && mem[i1] == (is_byte ? keep : s.wdata[15:8]))
            else flag_error($sformatf("row %0d memory %h %h after write of %h", r,
                                      mem[i1], mem[i0], s.wdata));
      end
      @(posedge clk);
      req_i <= 1'b0;
      do @(negedge clk); while (ack_o);
   endtask

   initial begin
      int e0;
      req_i   = 1'b0;
      addr_i  = '0;
      we_i    = 1'b0;
      byte_i  = 1'b0;
      wdata_i = '0;
      hold_i  = 1'b0;
      errors  = 0;
      repeat (5) @(negedge clk);
      assert (!ack_o && !ale_o && !hlda_o && !ad_oe_o && rd_n_o && wr_n_o && den_n_o && dtr_o)
         else flag_error("outputs wrong during reset");
      $display("reset values: %0d errors", errors);
      wait (rst === 1'b1);
      repeat (2) @(posedge clk);
      for (int r = 0; r < n_rows; r++) begin
         e0 = errors;
         run_row(r);
         $display("row %0d %s at %h: %0d errors", r, op_names[stim[r].op], stim[r].addr,
                  errors - e0);
      end
      errors += u_dut.u_props.fail_cnt;
      $display("%0d rows run, %0d errors", n_rows, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // watchdog
   initial begin
      #((10 + n_rows * 40) * 10);
      $display("timeout: requests did not complete in time");
      $display("test failed");
      $finish;
   end

endmodule

/* bench/biu_properties.sv */
/*
 * bus and handshake properties
 * bound into the bus interface unit top level
 */

`timescale 1ns/10ps

module biu_properties (
   input logic clk,
   input logic rst,
   input logic req_i,
   input logic ack_i,
   input logic ale_i,
   input logic rd_n_i,
   input logic wr_n_i,
   input logic hlda_i,
   input logic ad_oe_i
);

   int fail_cnt = 0;  // failed property count

   // only one strobe at a time
   rd_wr_excl: assert property (@(posedge clk) disable iff (!rst) !(!rd_n_i && !wr_n_i))
      else begin
         $error("rd_n and wr_n low together");
         fail_cnt++;
      end

   ale_hlda_excl: assert property (@(posedge clk) disable iff (!rst) !(ale_i && hlda_i))
      else begin
         $error("ale high while bus is granted away");
         fail_cnt++;
      end

   // ack may drop only once the client has let go
   ack_fall: assert property (@(posedge clk) disable iff (!rst) $fell(ack_i) |-> !$past(req_i))
      else begin
         $error("ack fell while req was still high");
         fail_cnt++;
      end

   hold_float: assert property (@(posedge clk) disable iff (!rst) hlda_i |-> !ad_oe_i)
      else begin
         $error("ad driven during hold");
         fail_cnt++;
      end

endmodule

/* bench/biu_clkgen.sv */
/*
 * testbench clock and reset
 * 10 ns clock, active-low reset held for 10 cycles
 */

`timescale 1ns/10ps

module biu_clkgen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b0;
      repeat (10) @(posedge clk_o);
      rst_o <= 1'b1;  // release on a clock edge
   end

endmodule

/* hw/biu_top.sv */
/*
 * 8088 bus interface unit
 * core request port, T-state sequencer and ad pin multiplexer
 */

`timescale 1ns/10ps

`include "biu_macros.svh"

module biu_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    req_i,
   input  biu_core_pkg::biu_addr_t addr_i,
   input  logic                    we_i,
   input  logic                    byte_i,
   input  biu_core_pkg::biu_data_u wdata_i,
   input  logic                    hold_i,
   input  biu_bus_pkg::biu_byte_t  ad_i,
   output logic                    ack_o,
   output biu_core_pkg::biu_data_u rdata_o,
   output biu_core_pkg::biu_addr_t a_o,
   output biu_bus_pkg::biu_byte_t  ad_o,
   output logic                    ad_oe_o,
   output logic                    ale_o,
   output logic                    rd_n_o,
   output logic                    wr_n_o,
   output logic                    den_n_o,
   output logic                    dtr_o,
   output logic                    hlda_o
);

   import biu_bus_pkg::*;
   import biu_core_pkg::*;

   // latched request
   logic        cyc_pend;
   biu_addr_t   cyc_addr;
   logic        cyc_we;
   logic        cyc_byte;
   biu_data_u   cyc_wdata;

   logic        cyc_done;
   biu_tstate_e tstate;
   logic [`BIU_IDX_W-1:0] byte_idx;
   biu_data_u   rd_word;

   biu_req_port u_req_port (
      .clk         (clk),
      .rst         (rst),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .we_i        (we_i),
      .byte_i      (byte_i),
      .wdata_i     (wdata_i),
      .cyc_done_i  (cyc_done),
      .rd_word_i   (rd_word),
      .ack_o       (ack_o),
      .rdata_o     (rdata_o),
      .cyc_pend_o  (cyc_pend),
      .cyc_addr_o  (cyc_addr),
      .cyc_we_o    (cyc_we),
      .cyc_byte_o  (cyc_byte),
      .cyc_wdata_o (cyc_wdata)
   );

   biu_bus_seq u_bus_seq (
      .clk        (clk),
      .rst        (rst),
      .cyc_pend_i (cyc_pend),
      .cyc_addr_i (cyc_addr),
      .cyc_we_i   (cyc_we),
      .cyc_byte_i (cyc_byte),
      .hold_i     (hold_i),
      .tstate_o   (tstate),
      .byte_idx_o (byte_idx),
      .cyc_done_o (cyc_done),
      .a_o        (a_o),
      .ale_o      (ale_o),
      .rd_n_o     (rd_n_o),
      .wr_n_o     (wr_n_o),
      .den_n_o    (den_n_o),
      .dtr_o      (dtr_o),
      .hlda_o     (hlda_o)
   );

   biu_pin_mux u_pin_mux (
      .clk         (clk),
      .rst         (rst),
      .tstate_i    (tstate),
      .byte_idx_i  (byte_idx),
      .cyc_we_i    (cyc_we),
      .cyc_byte_i  (cyc_byte),
      .cyc_wdata_i (cyc_wdata),
      .a_i         (a_o),
      .ad_i        (ad_i),
      .ad_o        (ad_o),
      .ad_oe_o     (ad_oe_o),
      .rd_word_o   (rd_word)
   );

endmodule

/* hw/biu_pin_mux.sv */
/*
 * pin multiplexer
 * drives address or write byte onto ad and assembles read bytes
 * into the core data word
 */

`timescale 1ns/10ps

`include "biu_macros.svh"

module biu_pin_mux (
   input  logic                     clk,
   input  logic                     rst,
   input  biu_bus_pkg::biu_tstate_e tstate_i,
   input  logic [`BIU_IDX_W-1:0]    byte_idx_i,
   input  logic                     cyc_we_i,
   input  logic                     cyc_byte_i,
   input  biu_core_pkg::biu_data_u  cyc_wdata_i,
   input  biu_core_pkg::biu_addr_t  a_i,
   input  biu_bus_pkg::biu_byte_t   ad_i,
   output biu_bus_pkg::biu_byte_t   ad_o,
   output logic                     ad_oe_o,
   output biu_core_pkg::biu_data_u  rd_word_o
);

   import biu_bus_pkg::*;
   import biu_core_pkg::*;

   biu_data_u rd_buf;
   biu_byte_t wr_lane;
   logic      strobe;

   assign strobe  = (tstate_i == ts_t2) || (tstate_i == ts_t3);
   assign wr_lane = byte_idx_i[0] ? cyc_wdata_i.bytes.hi : cyc_wdata_i.bytes.lo;

   always_comb begin
      ad_o    = '0;
      ad_oe_o = 1'b0;
      if (tstate_i == ts_t1) begin
         ad_o    = a_i[`BIU_BYTE_W-1:0];  // address phase
         ad_oe_o = 1'b1;
      end else if (strobe && cyc_we_i) begin
         ad_o    = wr_lane;
         ad_oe_o = 1'b1;
      end
   end

   // read byte lands in its lane at the end of T3
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rd_buf <= '0;
      end else if ((tstate_i == ts_t3) && !cyc_we_i) begin
         if (byte_idx_i[0])
            rd_buf.bytes.hi <= ad_i;
         else
            rd_buf.bytes.lo <= ad_i;
      end
   end

   always_comb begin
      if (cyc_byte_i)
         rd_word_o.word = {{`BIU_BYTE_W{rd_buf.bytes.lo[`BIU_BYTE_W-1]}}, rd_buf.bytes.lo};
      else
         rd_word_o.word = rd_buf.word;
   end

endmodule

/* hw/biu_bus_seq.sv */
/*
 * bus sequencer
 * runs T1-T3 once per byte, drives address and strobes,
 * grants hold only between requests
 */

`timescale 1ns/10ps

`include "biu_macros.svh"

module biu_bus_seq (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         cyc_pend_i,
   input  biu_core_pkg::biu_addr_t      cyc_addr_i,
   input  logic                         cyc_we_i,
   input  logic                         cyc_byte_i,
   input  logic                         hold_i,
   output biu_bus_pkg::biu_tstate_e     tstate_o,
   output logic [`BIU_IDX_W-1:0]        byte_idx_o,
   output logic                         cyc_done_o,
   output biu_core_pkg::biu_addr_t      a_o,
   output logic                         ale_o,
   output logic                         rd_n_o,
   output logic                         wr_n_o,
   output logic                         den_n_o,
   output logic                         dtr_o,
   output logic                         hlda_o
);

   import biu_bus_pkg::*;

   biu_tstate_e tstate_nxt;
   logic        last_byte;
   logic        strobe;   // T2 or T3
   logic        in_cyc;   // T1 to T3

   // a byte request ends after one pass, a word after the high byte
   assign last_byte  = cyc_byte_i || (byte_idx_o == {`BIU_IDX_W{1'b1}});
   assign cyc_done_o = (tstate_o == ts_t3) && last_byte;

   always_comb begin
      tstate_nxt = tstate_o;
      case (tstate_o)
         ts_idle: begin
            if (hold_i)
               tstate_nxt = ts_hold;  // hold beats a pending request
            else if (cyc_pend_i)
               tstate_nxt = ts_t1;
         end
         ts_t1:   tstate_nxt = ts_t2;
         ts_t2:   tstate_nxt = ts_t3;
         ts_t3:   tstate_nxt = last_byte ? ts_idle : ts_t1;
         ts_hold: if (!hold_i) tstate_nxt = ts_idle;
         default: tstate_nxt = ts_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         tstate_o   <= ts_idle;
         byte_idx_o <= '0;
      end else begin
         tstate_o <= tstate_nxt;
         if (tstate_o == ts_t3) begin
            if (last_byte)
               byte_idx_o <= '0;
            else
               byte_idx_o <= byte_idx_o + 1'b1;
         end
      end
   end

   assign strobe = (tstate_o == ts_t2) || (tstate_o == ts_t3);
   assign in_cyc = strobe || (tstate_o == ts_t1);

   // address of the byte in flight
   assign a_o = cyc_addr_i + {{(`BIU_ADDR_W-`BIU_IDX_W){1'b0}}, byte_idx_o};

   assign ale_o   = (tstate_o == ts_t1);
   assign rd_n_o  = !(strobe && !cyc_we_i);
   assign wr_n_o  = !(strobe && cyc_we_i);
   assign den_n_o = !strobe;
   assign dtr_o   = !(in_cyc && !cyc_we_i);  // low while bus drives toward us
   assign hlda_o  = (tstate_o == ts_hold);

endmodule

/* hw/biu_req_port.sv */
/*
 * request port
 * four-phase req/ack handshake with the core, latches one request
 * and returns the read word
 */

`timescale 1ns/10ps

module biu_req_port (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    req_i,
   input  biu_core_pkg::biu_addr_t addr_i,
   input  logic                    we_i,
   input  logic                    byte_i,
   input  biu_core_pkg::biu_data_u wdata_i,
   input  logic                    cyc_done_i,
   input  biu_core_pkg::biu_data_u rd_word_i,
   output logic                    ack_o,
   output biu_core_pkg::biu_data_u rdata_o,
   output logic                    cyc_pend_o,
   output biu_core_pkg::biu_addr_t cyc_addr_o,
   output logic                    cyc_we_o,
   output logic                    cyc_byte_o,
   output biu_core_pkg::biu_data_u cyc_wdata_o
);

   typedef enum logic {
      st_wait,
      st_acked
   } hs_state_e;

   hs_state_e state;
   logic      done_q;  // cyc_done delayed, read word is valid now
   logic      accept;

   // new request only once the previous one is fully retired
   assign accept = (state == st_wait) && req_i && !cyc_pend_o && !done_q;
   assign ack_o  = (state == st_acked);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state      <= st_wait;
         cyc_pend_o <= 1'b0;
         done_q     <= 1'b0;
      end else begin
         done_q <= cyc_done_i;
         if (cyc_done_i)
            cyc_pend_o <= 1'b0;
         else if (accept)
            cyc_pend_o <= 1'b1;
         case (state)
            st_wait:  if (done_q) state <= st_acked;
            st_acked: if (!req_i) state <= st_wait;  // client let go
            default:  state <= st_wait;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cyc_addr_o  <= addr_i;
         cyc_we_o    <= we_i;
         cyc_byte_o  <= byte_i;
         cyc_wdata_o <= wdata_i;
      end
      if (done_q)
         rdata_o <= rd_word_i;  // stable until next ack
   end

endmodule

/* hw/biu_core_pkg.sv */
/*
 * core package
 * types for the core-side request, its address and data word
 */

`include "biu_macros.svh"

package biu_core_pkg;

   typedef logic [`BIU_ADDR_W-1:0] biu_addr_t;

   // byte lanes of a word, little-endian on the bus
   typedef struct packed {
      biu_bus_pkg::biu_byte_t hi;
      biu_bus_pkg::biu_byte_t lo;
   } biu_lanes_t;

   // core sees the word, bus side picks a lane
   typedef union packed {
      logic [`BIU_WORD_W-1:0] word;
      biu_lanes_t             bytes;
   } biu_data_u;

endpackage

/* hw/biu_bus_pkg.sv */
/*
 * bus package
 * types for the external 8-bit multiplexed bus
 */

`include "biu_macros.svh"

package biu_bus_pkg;

   // T-state of the bus sequencer
   typedef enum logic [2:0] {
      ts_idle = 3'd0,
      ts_t1   = 3'd1,  // ale, address on ad
      ts_t2   = 3'd2,  // strobe low
      ts_t3   = 3'd3,  // capture or hold write byte
      ts_hold = 3'd4   // bus granted away
   } biu_tstate_e;

   // one byte on ad
   typedef logic [`BIU_BYTE_W-1:0] biu_byte_t;

endpackage

/* hw/biu_macros.svh */
/*
 * bus interface unit widths
 * fixed by the 8088 pin-out, shared by packages and modules
 */

`ifndef BIU_MACROS_SVH
`define BIU_MACROS_SVH

// physical address, 1 MB space
`define BIU_ADDR_W 20

`define BIU_BYTE_W 8  // multiplexed ad bus
`define BIU_WORD_W 16 // core data word

// byte index within one request, word needs two bytes
`define BIU_IDX_W 1

`endif
